/* source/sbox_pkg.sv */
// masked aes sbox definitions
package sbox_pkg;

    // two boolean shares throughout
    localparam int shares        = 2;
    localparam int and_count     = 34;
    // one fresh bit per masked and gate
    localparam int rand_width    = and_count;
    localparam int mid_in_width  = 21;
    localparam int mid_out_width = 18;

    typedef enum logic {
        DIR_FORWARD = 1'b0,
        DIR_INVERSE = 1'b1
    } sbox_dir_e;

    typedef logic [shares-1:0][7:0]               share_byte_t;
    typedef logic [shares-1:0][mid_in_width-1:0]  mid_in_t;
    typedef logic [shares-1:0][mid_out_width-1:0] mid_out_t;

    // sideband that follows each item down the pipe
    typedef struct packed {
        logic      valid;
        sbox_dir_e dir;
    } sbox_tag_t;

    typedef struct packed {
        logic        valid;
        sbox_dir_e   dir;
        share_byte_t data;
    } sbox_req_t;

    typedef struct packed {
        logic        valid;
        share_byte_t data;
    } sbox_rsp_t;

endpackage

/* source/dom_and.sv */
// two share masked and gate
`timescale 1ns/1ps

module dom_and (
    input  logic                        g_clk,
    input  logic                        rst_n,
    input  logic                        en,
    input  logic                        flush,
    input  logic [sbox_pkg::shares-1:0] a,
    input  logic [sbox_pkg::shares-1:0] b,
    input  logic                        rand_bit,
    output logic [sbox_pkg::shares-1:0] y
);

    logic [sbox_pkg::shares-1:0] inner_d;
    logic [sbox_pkg::shares-1:0] inner_q;
    logic [sbox_pkg::shares-1:0] cross_d;
    logic [sbox_pkg::shares-1:0] cross_q;

    always_comb begin
        inner_d = a & b;
        // cross terms land in opposite domains, hidden by the same fresh bit
        cross_d[0] = (a[0] & b[1]) ^ rand_bit;
        cross_d[1] = (a[1] & b[0]) ^ rand_bit;
    end

    // register before recombining, stops glitches reaching across domains
    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            inner_q <= '0;
            cross_q <= '0;
        end else if (flush) begin
            inner_q <= '0;
            cross_q <= '0;
        end else if (en) begin
            inner_q <= inner_d;
            cross_q <= cross_d;
        end
    end

    assign y = inner_q ^ cross_q;

endmodule

/* source/sbox_decode.sv */
// sbox top linear layers
`timescale 1ns/1ps

module sbox_decode (
    input  sbox_pkg::share_byte_t data,
    input  sbox_pkg::sbox_dir_e   dir,
    output sbox_pkg::mid_in_t     mid
);

    // forward aes top layer, 8 bits in, 21 bits out
    function automatic logic [20:0] fwd_top(input logic [7:0] x);
        logic [20:0] y;
        logic        t0;
        logic        t1;
        logic        t2;
        logic        t3;
        logic        t4;
        logic        t5;
        t0    = x[3] ^ x[1];
        t1    = x[6] ^ x[5];
        t2    = x[6] ^ x[2];
        t3    = x[5] ^ x[2];
        t4    = x[4] ^ x[0];
        t5    = x[1] ^ x[0];
        y[0]  = x[0];
        y[1]  = x[7] ^ x[4];
        y[2]  = x[7] ^ x[2];
        y[3]  = x[7] ^ x[1];
        y[4]  = x[4] ^ x[2];
        y[5]  = y[1] ^ t0;
        y[6]  = x[0] ^ y[5];
        y[7]  = x[0] ^ t1;
        y[8]  = y[5] ^ t1;
        y[9]  = y[3] ^ y[4];
        y[10] = y[5] ^ t2;
        y[11] = t0 ^ t2;
        y[12] = t0 ^ t3;
        y[13] = y[7] ^ y[12];
        y[14] = t1 ^ t4;
        y[15] = y[1] ^ y[14];
        y[16] = t1 ^ t5;
        y[17] = y[2] ^ y[16];
        y[18] = y[2] ^ y[8];
        y[19] = y[15] ^ y[13];
        y[20] = y[1] ^ t3;
        return y;
    endfunction

    // inverse layer; c set on share 0 only, so each xnor flips the value once
    function automatic logic [20:0] inv_top(input logic [7:0] x, input logic c);
        logic [20:0] y;
        logic        t0;
        logic        t1;
        logic        t2;
        logic        t3;
        logic        t4;
        t0    = x[1] ^ x[0];
        t1    = x[6] ^ x[1];
        t2    = x[5] ^ x[2] ^ c;
        t3    = x[2] ^ x[1] ^ c;
        t4    = x[5] ^ x[3] ^ c;
        y[17] = x[7] ^ x[4];
        y[16] = x[6] ^ x[4] ^ c;
        y[2]  = x[7] ^ x[6] ^ c;
        y[1]  = x[4] ^ x[3];
        y[18] = x[3] ^ x[0] ^ c;
        y[6]  = x[6] ^ y[17] ^ c;
        y[14] = y[16] ^ t0;
        y[7]  = x[0] ^ y[1] ^ c;
        y[8]  = y[2] ^ y[18];
        y[9]  = y[2] ^ t0;
        y[3]  = y[1] ^ t0;
        y[19] = x[5] ^ y[1] ^ c;
        y[13] = x[5] ^ y[14] ^ c;
        y[15] = y[18] ^ t1;
        y[4]  = x[3] ^ y[6];
        y[5]  = y[16] ^ t2;
        y[12] = t1 ^ t4;
        y[20] = y[1] ^ t3;
        y[11] = y[8] ^ y[20];
        y[10] = y[8] ^ t3;
        y[0]  = x[7] ^ t2;
        return y;
    endfunction

    always_comb begin
        for (int s = 0; s < sbox_pkg::shares; s++) begin
            if (dir == sbox_pkg::DIR_INVERSE) begin
                mid[s] = inv_top(data[s], s == 0);
            end else begin
                mid[s] = fwd_top(data[s]);
            end
        end
    end

endmodule

/* source/sbox_gf_inverse.sv */
// masked gf(2^8) inversion core
`timescale 1ns/1ps

module sbox_gf_inverse (
    input  logic                            g_clk,
    input  logic                            rst_n,
    input  logic                            en,
    input  logic                            flush,
    input  logic [sbox_pkg::rand_width-1:0] rand_bits,
    input  sbox_pkg::mid_in_t               mid_in,
    input  sbox_pkg::sbox_tag_t             tag_in,
    output sbox_pkg::mid_out_t              mid_out,
    output sbox_pkg::sbox_tag_t             tag_out
);

    typedef logic [sbox_pkg::shares-1:0] sh_t;
    typedef sh_t [sbox_pkg::mid_in_width-1:0] xbits_t;

    // bit-major view, one share pair per top-layer bit
    function automatic xbits_t bit_major(input sbox_pkg::mid_in_t m);
        xbits_t r;
        for (int i = 0; i < sbox_pkg::mid_in_width; i++) begin
            for (int s = 0; s < sbox_pkg::shares; s++) begin
                r[i][s] = m[s][i];
            end
        end
        return r;
    endfunction

    sh_t [sbox_pkg::and_count-1:0]     and_a;
    sh_t [sbox_pkg::and_count-1:0]     and_b;
    sh_t [sbox_pkg::and_count-1:0]     and_y;
    sh_t [sbox_pkg::mid_out_width-1:0] ys;
    xbits_t                            xs0;
    xbits_t                            xs1;
    xbits_t                            xs3;
    sbox_pkg::mid_in_t                 x_d1;
    sbox_pkg::mid_in_t                 x_d2;
    sbox_pkg::mid_in_t                 x_d3;
    sbox_pkg::sbox_tag_t [3:0]         tag_q;

    // layer outputs
    sh_t t1, t2, t4, t6, t7, t9, t11, t12, t14;
    sh_t t25, t31, t34, t29, t30, t32, t35;
    // xor network terms
    sh_t t0, t3, t5, t8, t10, t13, t15, t16, t17, t18, t19;
    sh_t t20, t21, t22, t23, t24, t26, t27, t28;
    sh_t t37, t38, t39, t40, t41, t42, t43, t44, t45;
    // alignment copies
    sh_t t21_q2, t23_q2, t24_q2, t27_q2;
    sh_t t21_q3, t23_q3, t33_q3, t36_q3;

    assign xs0 = bit_major(mid_in);
    assign xs1 = bit_major(x_d1);
    assign xs3 = bit_major(x_d3);

    // gates 0-8 layer 1, 9-11 layer 2, 12-15 layer 3, 16-33 layer 4
    assign and_a = {t43, t39, t40, t44, t41, t45, t42, t37, t38,
                    t43, t39, t40, t44, t41, t45, t42, t37, t38,
                    t24_q2, t27_q2, t26, t28,
                    t21, t20, t22,
                    xs0[2], xs0[4], xs0[1], xs0[15], xs0[16],
                    xs0[3], xs0[14], xs0[17], xs0[9]};
    assign and_b = {xs3[12], xs3[0], xs3[6], xs3[5], xs3[2], xs3[4], xs3[1], xs3[15], xs3[16],
                    xs3[3], xs3[14], xs3[17], xs3[9], xs3[8], xs3[20], xs3[11], xs3[13], xs3[7],
                    t34, t31, t24_q2, t27_q2,
                    t22, t23, t20,
                    xs0[8], xs0[20], xs0[11], xs0[13], xs0[7],
                    xs0[12], xs0[0], xs0[6], xs0[5]};

    for (genvar g = 0; g < sbox_pkg::and_count; g++) begin : gen_and
        dom_and u_dom_and (
            .g_clk    (g_clk),
            .rst_n    (rst_n),
            .en       (en),
            .flush    (flush),
            .a        (and_a[g]),
            .b        (and_b[g]),
            .rand_bit (rand_bits[g]),
            .y        (and_y[g])
        );
    end

    assign {t14, t12, t11, t9, t7, t6, t4, t2, t1} = and_y[8:0];
    assign {t34, t31, t25} = and_y[11:9];
    assign {t35, t32, t30, t29} = and_y[15:12];
    assign ys = and_y[sbox_pkg::and_count-1:sbox_pkg::and_count-sbox_pkg::mid_out_width];

    always_comb begin
        // after layer 1
        t0  = xs1[3] ^ xs1[12];
        t3  = xs1[10] ^ t1;
        t5  = t4 ^ t1;
        t8  = t0 ^ t6;
        t10 = t9 ^ t6;
        t13 = t12 ^ t11;
        t15 = t14 ^ t11;
        t16 = t3 ^ t2;
        t17 = t5 ^ xs1[18];
        t18 = t8 ^ t7;
        t19 = t10 ^ t15;
        t20 = t16 ^ t13;
        t21 = t17 ^ t15;
        t22 = t18 ^ t13;
        t23 = t19 ^ xs1[19];
        t24 = t22 ^ t23;
        t27 = t20 ^ t21;
        // after layer 2
        t26 = t21_q2 ^ t25;
        t28 = t23_q2 ^ t25;
        // after layer 3
        t37 = t21_q3 ^ t29;
        t38 = t32 ^ t33_q3;
        t39 = t23_q3 ^ t30;
        t40 = t35 ^ t36_q3;
        t41 = t38 ^ t40;
        t42 = t37 ^ t39;
        t43 = t37 ^ t38;
        t44 = t39 ^ t40;
        t45 = t42 ^ t41;
    end

    // linear terms ride alongside the and layers
    always_ff @(posedge g_clk) begin
        if (en) begin
            x_d1   <= mid_in;
            x_d2   <= x_d1;
            x_d3   <= x_d2;
            t21_q2 <= t21;
            t23_q2 <= t23;
            t24_q2 <= t24;
            t27_q2 <= t27;
            t21_q3 <= t21_q2;
            t23_q3 <= t23_q2;
            t33_q3 <= t27_q2 ^ t25;
            t36_q3 <= t24_q2 ^ t25;
        end
    end

    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            tag_q <= '0;
        end else if (flush) begin
            tag_q <= '0;
        end else if (en) begin
            tag_q <= {tag_q[2:0], tag_in};
        end
    end

    assign tag_out = tag_q[3];

    always_comb begin
        for (int i = 0; i < sbox_pkg::mid_out_width; i++) begin
            for (int s = 0; s < sbox_pkg::shares; s++) begin
                mid_out[s][i] = ys[i][s];
            end
        end
    end

    flush_empties_pipe: assert property (
        @(posedge g_clk) disable iff (!rst_n) flush |=> !tag_out.valid);

    reset_empties_pipe: assert property (
        @(posedge g_clk) $rose(rst_n) |-> !tag_out.valid);

endmodule

/* source/sbox_result.sv */
// sbox bottom linear layers
`timescale 1ns/1ps

module sbox_result (
    input  sbox_pkg::mid_out_t  mid,
    input  sbox_pkg::sbox_tag_t tag,
    output sbox_pkg::sbox_rsp_t rsp
);

    // forward aes bottom layer, c complements share 0 only
    function automatic logic [7:0] fwd_bot(input logic [17:0] x, input logic c);
        logic [29:0] t;
        logic [7:0]  y;
        t[0]  = x[11] ^ x[12];
        t[1]  = x[0] ^ x[6];
        t[2]  = x[14] ^ x[16];
        t[3]  = x[15] ^ x[5];
        t[4]  = x[4] ^ x[8];
        t[5]  = x[17] ^ x[11];
        t[6]  = x[12] ^ t[5];
        t[7]  = x[14] ^ t[3];
        t[8]  = x[1] ^ x[9];
        t[9]  = x[2] ^ x[3];
        t[10] = x[3] ^ t[4];
        t[11] = x[10] ^ t[2];
        t[12] = x[16] ^ x[1];
        t[13] = x[0] ^ t[0];
        t[14] = x[2] ^ x[11];
        t[15] = x[5] ^ t[1];
        t[16] = x[6] ^ t[0];
        t[17] = x[7] ^ t[1];
        t[18] = x[8] ^ t[8];
        t[19] = x[13] ^ t[4];
        t[20] = t[0] ^ t[1];
        t[21] = t[1] ^ t[7];
        t[22] = t[3] ^ t[12];
        t[23] = t[18] ^ t[2];
        t[24] = t[15] ^ t[9];
        t[25] = t[6] ^ t[10];
        t[26] = t[7] ^ t[9];
        t[27] = t[8] ^ t[10];
        t[28] = t[11] ^ t[14];
        t[29] = t[11] ^ t[17];
        y[0]  = t[6] ^ t[23] ^ c;
        y[1]  = t[13] ^ t[27] ^ c;
        y[2]  = t[25] ^ t[29];
        y[3]  = t[20] ^ t[22];
        y[4]  = t[6] ^ t[21];
        y[5]  = t[19] ^ t[28] ^ c;
        y[6]  = t[16] ^ t[26] ^ c;
        y[7]  = t[6] ^ t[24];
        return y;
    endfunction

    // inverse bottom layer, purely linear
    function automatic logic [7:0] inv_bot(input logic [17:0] x);
        logic [28:0] t;
        logic [7:0]  y;
        t[0]  = x[2] ^ x[11];
        t[1]  = x[8] ^ x[9];
        t[2]  = x[4] ^ x[12];
        t[3]  = x[15] ^ x[0];
        t[4]  = x[16] ^ x[6];
        t[5]  = x[14] ^ x[1];
        t[6]  = x[17] ^ x[10];
        t[7]  = t[0] ^ t[1];
        t[8]  = x[0] ^ x[3];
        t[9]  = x[5] ^ x[13];
        t[10] = x[7] ^ t[4];
        t[11] = t[0] ^ t[3];
        t[12] = x[14] ^ x[16];
        t[13] = x[17] ^ x[1];
        t[14] = x[17] ^ x[12];
        t[15] = x[4] ^ x[9];
        t[16] = x[7] ^ x[11];
        t[17] = x[8] ^ t[2];
        t[18] = x[13] ^ t[5];
        t[19] = t[2] ^ t[3];
        t[20] = t[4] ^ t[6];
        t[21] = t[2] ^ t[7];
        t[22] = t[7] ^ t[8];
        t[23] = t[5] ^ t[7];
        t[24] = t[6] ^ t[10];
        t[25] = t[9] ^ t[11];
        t[26] = t[10] ^ t[18];
        t[27] = t[11] ^ t[24];
        t[28] = t[15] ^ t[20];
        y[0]  = t[9] ^ t[16];
        y[1]  = t[14] ^ t[22];
        y[2]  = t[19] ^ t[23];
        y[3]  = t[22] ^ t[26];
        y[4]  = t[12] ^ t[21];
        y[5]  = t[17] ^ t[27];
        y[6]  = t[25] ^ t[28];
        y[7]  = t[13] ^ t[21];
        return y;
    endfunction

    always_comb begin
        rsp.valid = tag.valid;
        for (int s = 0; s < sbox_pkg::shares; s++) begin
            if (tag.dir == sbox_pkg::DIR_INVERSE) begin
                rsp.data[s] = inv_bot(mid[s]);
            end else begin
                rsp.data[s] = fwd_bot(mid[s], s == 0);
            end
        end
    end

    // valid output must be fully resolved in both shares
    always_comb begin
        if (rsp.valid) begin
            assert final (!$isunknown(rsp.data))
                else $error("unknown bits on a valid sbox response");
        end
    end

endmodule

/* source/masked_sbox.sv */
// masked aes sbox top level
`timescale 1ns/1ps

module masked_sbox (
    input  logic                            g_clk,
    input  logic                            rst_n,
    input  logic                            en,
    input  logic                            flush,
    input  sbox_pkg::sbox_req_t             req,
    input  logic [sbox_pkg::rand_width-1:0] rand_bits,
    output sbox_pkg::sbox_rsp_t             rsp
);

    sbox_pkg::mid_in_t   mid_in;
    sbox_pkg::mid_out_t  mid_out;
    sbox_pkg::sbox_tag_t tag_in;
    sbox_pkg::sbox_tag_t tag_out;

    assign tag_in.valid = req.valid;
    assign tag_in.dir   = req.dir;

    sbox_decode u_decode (
        .data (req.data),
        .dir  (req.dir),
        .mid  (mid_in)
    );

    // four enabled cycles from here to the bottom layer
    sbox_gf_inverse u_gf_inverse (
        .g_clk     (g_clk),
        .rst_n     (rst_n),
        .en        (en),
        .flush     (flush),
        .rand_bits (rand_bits),
        .mid_in    (mid_in),
        .tag_in    (tag_in),
        .mid_out   (mid_out),
        .tag_out   (tag_out)
    );

    sbox_result u_result (
        .mid (mid_out),
        .tag (tag_out),
        .rsp (rsp)
    );

endmodule

/* test/tb_masked_sbox.sv */
// masked sbox testbench
`timescale 1ns/1ps

module tb_masked_sbox;

    // expected result of one accepted item
    typedef struct packed {
        logic        mark;
        logic [31:0] accept_edge;
        logic [7:0]  value;
    } exp_item_t;

    typedef struct packed {
        sbox_pkg::sbox_dir_e dir;
        logic [7:0]          din;
        logic [7:0]          dout;
    } vector_t;

    localparam int max_vectors = 64;
    localparam int drain_limit = 64;

    logic                            g_clk;
    logic                            rst_n;
    logic                            en;
    logic                            flush;
    sbox_pkg::sbox_req_t             req;
    logic [sbox_pkg::rand_width-1:0] rand_bits;
    sbox_pkg::sbox_rsp_t             rsp;

    vector_t             vectors [max_vectors];
    int                  vec_count = 0;
    exp_item_t           exp_q[$];
    logic [7:0]          share_q[$];
    logic [31:0]         enabled_edges = '0;
    logic                last_edge_en = 1'b0;
    logic                last_edge_flush = 1'b0;
    sbox_pkg::sbox_rsp_t prev_rsp = '0;
    int                  check_errors = 0;
    int                  timeout_errors = 0;
    int                  setup_errors = 0;
    int                  flushed_items = 0;

    masked_sbox u_masked_sbox (
        .g_clk     (g_clk),
        .rst_n     (rst_n),
        .en        (en),
        .flush     (flush),
        .req       (req),
        .rand_bits (rand_bits),
        .rsp       (rsp)
    );

    always #20 g_clk = ~g_clk;

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            check_errors++;
            $display("ERROR at %0t: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic refresh_random();
        logic [63:0] rnd;
        rnd = {$urandom, $urandom};
        rand_bits = rnd[sbox_pkg::rand_width-1:0];
    endtask

    task automatic load_vectors();
        int    fd;
        int    dir_val;
        int    din_val;
        int    dout_val;
        string line;
        fd = $fopen("test/sbox_testdata.txt", "r");
        if (fd == 0) begin
            setup_errors++;
            $display("could not open test/sbox_testdata.txt");
            return;
        end
        while (!$feof(fd) && vec_count < max_vectors) begin
            line = "";
            void'($fgets(line, fd));
            // lines starting with # describe the columns
            if (line.len() > 0 && line[0] != "#") begin
                if ($sscanf(line, "%d %h %h", dir_val, din_val, dout_val) == 3) begin
                    vectors[vec_count].dir  = sbox_pkg::sbox_dir_e'(dir_val[0]);
                    vectors[vec_count].din  = din_val[7:0];
                    vectors[vec_count].dout = dout_val[7:0];
                    vec_count++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge g_clk);
            #2;
            en = 1'b1;
            req.valid = 1'b0;
            refresh_random();
        end
    endtask

    // fresh share mask and gate randomness for every item
    task automatic drive_item(input vector_t v, input bit gaps, input bit mark);
        logic [31:0] mask;
        logic [31:0] rnd;
        int          stalls;
        exp_item_t   item;
        @(posedge g_clk);
        #2;
        if (gaps) begin
            stalls = $urandom % 4;
            repeat (stalls) begin
                rnd = $urandom;
                en = 1'b0;
                // ignored while stalled
                req.valid = rnd[0];
                refresh_random();
                @(posedge g_clk);
                #2;
            end
        end
        mask = $urandom;
        en = 1'b1;
        req.valid = 1'b1;
        req.dir = v.dir;
        req.data[1] = mask[7:0];
        req.data[0] = v.din ^ mask[7:0];
        refresh_random();
        item.mark = mark;
        item.accept_edge = enabled_edges + 1;
        item.value = v.dout;
        exp_q.push_back(item);
    endtask

    task automatic flush_pipe();
        @(posedge g_clk);
        #2;
        en = 1'b1;
        flush = 1'b1;
        req.valid = 1'b0;
        refresh_random();
        @(posedge g_clk);
        #2;
        flush = 1'b0;
    endtask

    task automatic wait_drain(input string phase);
        int waited;
        waited = 0;
        idle_cycles(1);
        while (exp_q.size() != 0 && waited < drain_limit) begin
            idle_cycles(1);
            waited++;
        end
        if (exp_q.size() != 0) begin
            timeout_errors++;
            $display("timeout: %0d responses never arrived in the %s", exp_q.size(), phase);
            exp_q.delete();
        end
    endtask

    task automatic check_mask_variation();
        int distinct;
        distinct = 0;
        foreach (share_q[i]) begin
            if (share_q[i] !== share_q[0]) begin
                distinct++;
            end
        end
        check_value(32'(share_q.size()), 32'd6, "repeated items seen");
        check_value(32'(distinct != 0), 32'd1, "output shares vary with the masks");
    endtask

    always @(posedge g_clk) begin
        last_edge_en = en;
        last_edge_flush = flush;
        if (en) begin
            enabled_edges = enabled_edges + 1;
        end
    end

    // check responses at the falling edge
    always @(negedge g_clk) begin
        exp_item_t item;
        if (rst_n) begin
            if (last_edge_flush) begin
                check_value(32'(rsp.valid), 32'd0, "valid after flush");
                flushed_items += exp_q.size();
                exp_q.delete();
            end else if (!last_edge_en) begin
                check_value(32'(rsp), 32'(prev_rsp), "response held while en low");
            end else if (rsp.valid) begin
                if (exp_q.size() == 0) begin
                    check_value(32'(rsp.valid), 32'd0, "response with no item in flight");
                end else begin
                    item = exp_q.pop_front();
                    check_value(32'(rsp.data[0] ^ rsp.data[1]), 32'(item.value),
                                "unmasked output");
                    check_value(enabled_edges, item.accept_edge + 3, "latency in enabled edges");
                    if (item.mark) begin
                        share_q.push_back(rsp.data[0]);
                    end
                end
            end
        end
        prev_rsp = rsp;
    end

    initial begin
        void'($urandom(32'h0888_b07c));
        $timeformat(-9, 0, " ns", 0);
        g_clk = 1'b0;
        rst_n = 1'b0;
        en = 1'b0;
        flush = 1'b0;
        req = '0;
        rand_bits = '0;
        repeat (4) @(posedge g_clk);
        #2;
        rst_n = 1'b1;
        load_vectors();
        if (vec_count == 0) begin
            setup_errors++;
            $display("no test vectors were loaded");
        end else begin
            // empty pipe stays quiet
            idle_cycles(6);
            check_value(32'(rsp.valid), 32'd0, "valid before any item");
            for (int i = 0; i < vec_count; i++) begin
                if (vectors[i].dir == sbox_pkg::DIR_FORWARD) begin
                    drive_item(vectors[i], 1'b0, 1'b0);
                end
            end
            wait_drain("forward run");
            for (int i = 0; i < vec_count; i++) begin
                if (vectors[i].dir == sbox_pkg::DIR_INVERSE) begin
                    drive_item(vectors[i], 1'b0, 1'b0);
                end
            end
            wait_drain("inverse run");
            // file order mixes both directions
            for (int i = 0; i < vec_count; i++) begin
                drive_item(vectors[i], 1'b0, 1'b0);
            end
            wait_drain("mixed run");
            for (int i = 0; i < vec_count; i++) begin
                drive_item(vectors[i], 1'b1, 1'b0);
            end
            wait_drain("stalled run");
            // three items in flight when the flush lands
            for (int i = 0; i < 3 && i < vec_count; i++) begin
                drive_item(vectors[i], 1'b0, 1'b0);
            end
            flush_pipe();
            for (int i = 0; i < vec_count; i++) begin
                drive_item(vectors[i], 1'b0, 1'b0);
            end
            wait_drain("run after flush");
            check_value(32'(flushed_items), 32'(vec_count < 3 ? vec_count : 3),
                        "items dropped by flush");
            repeat (6) begin
                drive_item(vectors[0], 1'b0, 1'b1);
            end
            wait_drain("repeated vector run");
            check_mask_variation();
        end
        $display("errors: %0d check, %0d timeout, %0d setup",
                 check_errors, timeout_errors, setup_errors);
        if (check_errors == 0 && timeout_errors == 0 && setup_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* build.f */
source/sbox_pkg.sv
source/dom_and.sv
source/sbox_decode.sv
source/sbox_gf_inverse.sv
source/sbox_result.sv
source/masked_sbox.sv
test/tb_masked_sbox.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_masked_sbox
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# the simulation passes only if the log holds the pass message
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/sbox_testdata.txt */
# direction (0 forward, 1 inverse), input byte, expected output byte
# bytes in hex, one vector per line
0 00 63
0 01 7c
1 63 00
0 53 ed
1 ed 53
0 ff 16
1 16 ff
0 10 ca
0 11 82
1 00 52
0 55 fc
1 fc 55
0 80 cd
1 cd 80
0 aa ac
0 c3 2e
1 d2 7f
0 3c eb
